/* list.f */
rv_pkg.sv
rv_decode.sv
rv_operand.sv
rv_execute.sv
rv_core_top.sv
tb_rv_core.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_rv_core -f list.f -o sim_rv_core

./obj_dir/sim_rv_core > sim.log 2>&1 || true
cat sim.log

if grep -qx "sim passed" sim.log; then
    exit 0
fi
exit 1

/* rv_core_top.sv */
module rv_core_top import rv_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  inst_valid,
    input  logic [31:0]           inst,
    output logic                  ret_valid,
    output logic [reg_addr_w-1:0] ret_rd,
    output logic [xlen-1:0]       ret_value
);

    decoded_t dec;
    issue_t   iss;
    result_t  ex_fwd;
    result_t  wb;

    rv_decode u_rv_decode (
        .clk        (clk),
        .arst_n     (arst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .dec        (dec)
    );

    rv_operand u_rv_operand (
        .clk    (clk),
        .arst_n (arst_n),
        .dec    (dec),
        .ex_fwd (ex_fwd),
        .wb     (wb),
        .iss    (iss)
    );

    rv_execute u_rv_execute (
        .clk    (clk),
        .arst_n (arst_n),
        .iss    (iss),
        .ex_fwd (ex_fwd),
        .wb     (wb)
    );

    // retire port is the registered result
    assign ret_valid = wb.valid;
    assign ret_rd    = wb.rd;
    assign ret_value = wb.value;

endmodule

/* rv_decode.sv */
module rv_decode import rv_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        inst_valid,
    input  logic [31:0] inst,
    output decoded_t    dec
);

    opcode_e         opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [xlen-1:0] pc_q;
    logic [xlen-1:0] i_imm;
    logic [xlen-1:0] u_imm;
    logic [xlen-1:0] imm;
    alu_op_e         alu_op;
    logic            src_a_pc;
    logic            src_b_imm;
    logic            supported;
    decoded_t        dec_d;

    assign opcode = opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign i_imm = {{(xlen-12){inst[31]}}, inst[31:20]};  // sign extend
    assign u_imm = {inst[31:12], 12'b0};

    // funct3 table shared by reg and imm forms, alt picks sub / sra
    function automatic alu_op_e base_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'd0:    return alt ? alu_sub : alu_add;
            3'd1:    return alu_sll;
            3'd2:    return alu_slt;
            3'd3:    return alu_sltu;
            3'd4:    return alu_xor;
            3'd5:    return alt ? alu_sra : alu_srl;
            3'd6:    return alu_or;
            default: return alu_and;
        endcase
    endfunction

    always_comb begin
        alu_op    = alu_add;
        src_a_pc  = 1'b0;
        src_b_imm = 1'b0;
        supported = 1'b1;
        imm       = i_imm;
        case (opcode)
            op_reg: begin
                if (funct7 == 7'b0000001) begin
                    alu_op    = alu_mul;
                    supported = (funct3 == 3'd0);  // mul only, no mulh / div
                end else if (funct7 == 7'b0100000) begin
                    alu_op    = base_op(funct3, 1'b1);
                    supported = (funct3 == 3'd0) || (funct3 == 3'd5);
                end else begin
                    alu_op    = base_op(funct3, 1'b0);
                    supported = (funct7 == 7'b0);
                end
            end
            op_imm: begin
                src_b_imm = 1'b1;
                alu_op    = base_op(funct3, (funct3 == 3'd5) && funct7[5]);
                if (funct3 == 3'd1)
                    supported = (funct7 == 7'b0);
                else if (funct3 == 3'd5)
                    supported = (funct7 == 7'b0) || (funct7 == 7'b0100000);
            end
            op_lui: begin
                alu_op    = alu_pass_b;
                src_b_imm = 1'b1;
                imm       = u_imm;
            end
            op_auipc: begin
                src_a_pc  = 1'b1;
                src_b_imm = 1'b1;
                imm       = u_imm;
            end
            default: supported = 1'b0;
        endcase
    end

    always_comb begin
        dec_d.valid     = inst_valid;
        dec_d.wen       = supported && (inst[11:7] != '0);
        dec_d.rs1       = inst[19:15];
        dec_d.rs2       = inst[24:20];
        dec_d.rd        = inst[11:7];
        dec_d.alu_op    = alu_op;
        dec_d.src_a_pc  = src_a_pc;
        dec_d.src_b_imm = src_b_imm;
        dec_d.pc        = pc_q;
        dec_d.imm       = imm;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc_q <= '0;
            dec  <= '0;
        end else begin
            dec <= dec_d;
            if (inst_valid)
                pc_q <= pc_q + pc_step;  // idle cycles hold the pc
        end
    end

endmodule

/* rv_execute.sv */
module rv_execute import rv_pkg::*; (
    input  logic    clk,
    input  logic    arst_n,
    input  issue_t  iss,
    output result_t ex_fwd,
    output result_t wb
);

    logic [4:0]             shamt;
    logic signed [xlen-1:0] product;
    logic [xlen-1:0]        result;

    assign shamt   = iss.b[4:0];
    assign product = $signed(iss.a) * $signed(iss.b);  // low word of the signed product

    always_comb begin
        case (iss.alu_op)
            alu_add:    result = iss.a + iss.b;
            alu_sub:    result = iss.a - iss.b;
            alu_sll:    result = iss.a << shamt;
            alu_slt:    result = {{(xlen-1){1'b0}}, $signed(iss.a) < $signed(iss.b)};
            alu_sltu:   result = {{(xlen-1){1'b0}}, iss.a < iss.b};
            alu_xor:    result = iss.a ^ iss.b;
            alu_srl:    result = iss.a >> shamt;
            alu_sra:    result = $unsigned($signed(iss.a) >>> shamt);
            alu_or:     result = iss.a | iss.b;
            alu_and:    result = iss.a & iss.b;
            alu_pass_b: result = iss.b;
            alu_mul:    result = product;
            default:    result = '0;
        endcase
    end

    // same-cycle result for the operand stage
    always_comb begin
        ex_fwd.valid = iss.valid && iss.wen && (iss.rd != '0);
        ex_fwd.rd    = iss.rd;
        ex_fwd.value = result;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            wb <= '0;
        else
            wb <= ex_fwd;
    end

endmodule

/* rv_operand.sv */
module rv_operand import rv_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  decoded_t dec,
    input  result_t  ex_fwd,
    input  result_t  wb,
    output issue_t   iss
);

    logic [xlen-1:0] regs [num_regs];
    logic [xlen-1:0] rs1_val;
    logic [xlen-1:0] rs2_val;
    issue_t          iss_d;

    // youngest producer wins, x0 always reads zero
    function automatic logic [xlen-1:0] resolve(
        input logic [reg_addr_w-1:0] rs,
        input result_t               ex,
        input result_t               w,
        input logic [xlen-1:0]       rf
    );
        if (rs == '0)
            return '0;
        else if (ex.valid && (ex.rd == rs))
            return ex.value;
        else if (w.valid && (w.rd == rs))
            return w.value;
        else
            return rf;
    endfunction

    // architectural register file
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid) begin
            regs[wb.rd] <= wb.value;  // wb never carries x0
        end
    end

    assign rs1_val = resolve(dec.rs1, ex_fwd, wb, regs[dec.rs1]);
    assign rs2_val = resolve(dec.rs2, ex_fwd, wb, regs[dec.rs2]);

    always_comb begin
        iss_d.valid  = dec.valid;
        iss_d.wen    = dec.wen;
        iss_d.rd     = dec.rd;
        iss_d.alu_op = dec.alu_op;
        iss_d.a      = dec.src_a_pc ? dec.pc : rs1_val;
        iss_d.b      = dec.src_b_imm ? dec.imm : rs2_val;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            iss <= '0;
        else
            iss <= iss_d;
    end

endmodule

/* rv_pkg.sv */
package rv_pkg;

    localparam int unsigned xlen       = 32;
    localparam int unsigned reg_addr_w = 5;
    localparam int unsigned num_regs   = 32;

    localparam logic [xlen-1:0] pc_step = 32'd4;  // bytes per instruction

    // major opcodes kept in this core, anything else is unsupported
    typedef enum logic [6:0] {
        op_reg   = 7'b0110011,
        op_imm   = 7'b0010011,
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b,  // lui
        alu_mul
    } alu_op_e;

    // decode -> operand
    typedef struct packed {
        logic                  valid;
        logic                  wen;
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rd;
        alu_op_e               alu_op;
        logic                  src_a_pc;   // auipc
        logic                  src_b_imm;
        logic [xlen-1:0]       pc;
        logic [xlen-1:0]       imm;
    } decoded_t;

    // operand -> execute
    typedef struct packed {
        logic                  valid;
        logic                  wen;
        logic [reg_addr_w-1:0] rd;
        alu_op_e               alu_op;
        logic [xlen-1:0]       a;
        logic [xlen-1:0]       b;
    } issue_t;

    // completed result, valid only for a write to rd != x0
    typedef struct packed {
        logic                  valid;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       value;
    } result_t;

endpackage

/* rv_testdata.txt */
# columns: valid  instruction  expect  rd  value   (all hex, one line per input cycle)
# expected values are the retirement each instruction must produce, if any
1 00500093 1 01 00000005   # addi x1, x0, 5
1 ffd00113 1 02 fffffffd   # addi x2, x0, -3
1 002081b3 1 03 00000002   # add  x3, x1, x2
1 40110233 1 04 fffffff8   # sub  x4, x2, x1
1 401252b3 1 05 ffffffff   # sra  x5, x4, x1
1 00125333 1 06 07ffffff   # srl  x6, x4, x1
1 001093b3 1 07 000000a0   # sll  x7, x1, x1
1 00112433 1 08 00000001   # slt  x8, x2, x1
1 001134b3 1 09 00000000   # sltu x9, x2, x1
1 0020c533 1 0a fffffff8   # xor  x10, x1, x2
1 0020e5b3 1 0b fffffffd   # or   x11, x1, x2
1 0020f633 1 0c 00000005   # and  x12, x1, x2
1 ffe12693 1 0d 00000001   # slti  x13, x2, -2
1 fff0b713 1 0e 00000001   # sltiu x14, x1, -1
1 00309793 1 0f 00000028   # slli  x15, x1, 3
1 01c25813 1 10 0000000f   # srli  x16, x4, 28
1 40225893 1 11 fffffffe   # srai  x17, x4, 2
1 fff0c913 1 12 fffffffa   # xori  x18, x1, -1
1 0f017993 1 13 000000f0   # andi  x19, x2, 0xf0
1 7ff06a13 1 14 000007ff   # ori   x20, x0, 0x7ff
1 00100a93 1 15 00000001   # addi x21, x0, 1
1 002a8a93 1 15 00000003   # addi x21, x21, 2
1 003a8a93 1 15 00000006   # addi x21, x21, 3
1 004a8a93 1 15 0000000a   # addi x21, x21, 4
1 00700b93 1 17 00000007   # addi x23, x0, 7
0 06300b93 0 00 00000000   # idle, addi x23 must not run
1 015b8c33 1 18 00000011   # add x24, x23, x21
1 017c0cb3 1 19 00000018   # add x25, x24, x23
1 12345d37 1 1a 12345000   # lui   x26, 0x12345
1 00001d97 1 1b 00001070   # auipc x27, 0x1 at pc 0x70
0 00001d97 0 00 00000000   # idle
0 00000000 0 00 00000000   # idle
1 00000e17 1 1c 00000074   # auipc x28, 0 at pc 0x74
1 02208eb3 1 1d fffffff1   # mul x29, x1, x2
1 02210f33 1 1e 00000009   # mul x30, x2, x2
1 03a20fb3 1 1f 6e5d8000   # mul x31, x4, x26
1 00908013 0 00 00000000   # addi x0, x1, 9
1 001003b3 1 07 00000005   # add x7, x0, x1
1 00112023 0 00 00000000   # sw x1, 0(x2)
1 0220c433 0 00 00000000   # div x8, x1, x2
1 400084b3 1 09 00000005   # sub x9, x1, x0
1 00040533 1 0a 00000001   # add x10, x8, x0

/* tb_rv_core.sv */
module tb_rv_core import rv_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    // one line of the test data file
    typedef struct packed {
        logic                  valid;
        logic [31:0]           inst;
        logic                  check;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       value;
    } vector_t;

    logic                  clk;
    logic                  arst_n;
    logic                  inst_valid;
    logic [31:0]           inst;
    logic                  ret_valid;
    logic [reg_addr_w-1:0] ret_rd;
    logic [xlen-1:0]       ret_value;

    vector_t     vectors[$];
    result_t     expected_q[$];
    result_t     head;
    int unsigned cycle_count = 0;
    int unsigned cycle_limit = 0;

    rv_core_top u_rv_core_top (
        .clk        (clk),
        .arst_n     (arst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .ret_valid  (ret_valid),
        .ret_rd     (ret_rd),
        .ret_value  (ret_value)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("sim failed");
        $fatal(1, "run aborted");
    endtask

    task automatic check_equal(
        input string           what,
        input logic [xlen-1:0] got,
        input logic [xlen-1:0] expected
    );
        if (got !== expected)
            abort_run($sformatf("ERR %0t: %s is %h, expected %h", $time, what, got, expected));
    endtask

    // blank lines and lines starting with # are skipped
    task automatic load_vectors();
        int                    fd;
        int                    fields;
        string                 line;
        logic                  v;
        logic [31:0]           word;
        logic                  c;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       value;
        vector_t               vec;
        fd = $fopen("rv_testdata.txt", "r");
        if (fd == 0) begin
            abort_run("could not open rv_testdata.txt for reading");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) != 0 && line.len() >= 2 && line[0] != "#") begin
                    fields = $sscanf(line, "%h %h %h %h %h", v, word, c, rd, value);
                    if (fields != 5) begin
                        abort_run({"test data line could not be parsed: ", line});
                    end else begin
                        vec.valid = v;
                        vec.inst  = word;
                        vec.check = c;
                        vec.rd    = rd;
                        vec.value = value;
                        vectors.push_back(vec);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // run limit, counted from reset release
    always @(posedge clk) begin
        if (arst_n) begin
            cycle_count <= cycle_count + 1;
            if (cycle_limit != 0 && cycle_count >= cycle_limit)
                abort_run($sformatf("timeout: run did not finish within %0d cycles", cycle_limit));
        end
    end

    // outputs settle long before the falling edge
    always @(negedge clk) begin
        if (arst_n && ret_valid) begin
            if (expected_q.size() == 0) begin
                abort_run($sformatf("retirement of x%0d at %0t when none was expected",
                                    ret_rd, $time));
            end else begin
                head = expected_q.pop_front();
                check_equal("ret_rd", 32'(ret_rd), 32'(head.rd));
                check_equal("ret_value", ret_value, head.value);
            end
        end
    end

    initial begin
        result_t item;
        int      waited;
        arst_n     = 1'b0;
        inst_valid = 1'b0;
        inst       = '0;
        waited     = 0;
        load_vectors();
        cycle_limit = vectors.size() + 20;

        repeat (5) @(posedge clk);
        arst_n <= 1'b1;

        foreach (vectors[i]) begin
            @(posedge clk);
            inst_valid <= vectors[i].valid;
            inst       <= vectors[i].inst;
            if (vectors[i].valid && vectors[i].check) begin
                item.valid = 1'b1;
                item.rd    = vectors[i].rd;
                item.value = vectors[i].value;
                expected_q.push_back(item);
            end
        end
        @(posedge clk);
        inst_valid <= 1'b0;
        inst       <= '0;

        while (expected_q.size() != 0 && waited < 10) begin
            @(posedge clk);
            waited++;
        end
        repeat (4) @(posedge clk);  // catch stray retirements

        if (expected_q.size() != 0) begin
            abort_run($sformatf("%0d expected retirements never arrived", expected_q.size()));
        end else begin
            $display("sim passed");
            $finish;
        end
    end

endmodule
